// File: bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ********************
// Model TLB
// ********************
tlb_entry_t model_tlb [TLB_ENTRIES];

function automatic void model_reset();
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        model_tlb[i] = '0;
    end
endfunction

// The stored G bit is set only when both halves of the pair are global
function automatic void model_write(tlb_idx_t idx, entryhi_t hi, entrylo_t lo0, entrylo_t lo1);
    tlb_entry_t e;
    e.vpn2 = hi.vpn2;
    e.asid = hi.asid;
    e.g    = lo0.g & lo1.g;
    e.pfn0 = lo0.pfn;
    e.c0   = lo0.c;
    e.d0   = lo0.d;
    e.v0   = lo0.v;
    e.pfn1 = lo1.pfn;
    e.c1   = lo1.c;
    e.d1   = lo1.d;
    e.v1   = lo1.v;
    model_tlb[idx] = e;
endfunction

// First matching entry in index order wins
function automatic void model_match(input logic [18:0] vpn2, input logic [7:0] asid,
                                    output logic hit, output tlb_idx_t idx);
    hit = 1'b0;
    idx = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        if (!hit && model_tlb[i].vpn2 == vpn2 &&
            (model_tlb[i].asid == asid || model_tlb[i].g)) begin
            hit = 1'b1;
            idx = tlb_idx_t'(i);
        end
    end
endfunction

function automatic void ref_translate(input vaddr_u va, input logic [7:0] asid,
                                      input logic k0_unc, output tu_resp_t r,
                                      output tu_fault_t f);
    logic        hit;
    tlb_idx_t    idx;
    tlb_entry_t  e;
    logic [31:0] w;
    logic [19:0] pfn;
    logic [2:0]  c;
    logic        d;
    logic        v;
    w = va;
    f = '0;
    if (w[31:29] == 3'b100 || w[31:29] == 3'b101) begin  // kseg0 and kseg1
        r.paddr    = {3'b000, w[28:0]};
        r.uncached = (w[31:29] == 3'b101) || k0_unc;
    end else begin
        model_match(w[31:13], asid, hit, idx);
        e          = model_tlb[idx];
        pfn        = w[12] ? e.pfn1 : e.pfn0;
        c          = w[12] ? e.c1 : e.c0;
        d          = w[12] ? e.d1 : e.d0;
        v          = w[12] ? e.v1 : e.v0;
        r.paddr    = {pfn, w[11:0]};
        r.uncached = (c == C_UNCACHED);
        f.refill   = !hit;
        f.invalid  = hit && !v;
        f.modified = hit && v && !d;
    end
endfunction

function automatic index_t ref_probe(entryhi_t hi);
    index_t   r;
    logic     hit;
    tlb_idx_t idx;
    model_match(hi.vpn2, hi.asid, hit, idx);
    r       = '0;
    r.p     = !hit;
    r.index = idx;
    return r;
endfunction

function automatic tu_op_resp_t ref_read(tu_op_resp_t prev, tlb_idx_t idx);
    tu_op_resp_t r;
    tlb_entry_t  e;
    r          = prev;  // Index stays as the last probe left it
    e          = model_tlb[idx];
    r.entryhi  = '{vpn2: e.vpn2, zero: '0, asid: e.asid};
    r.entrylo0 = '{fill: '0, pfn: e.pfn0, c: e.c0, d: e.d0, v: e.v0, g: e.g};
    r.entrylo1 = '{fill: '0, pfn: e.pfn1, c: e.c1, d: e.d1, v: e.v1, g: e.g};
    return r;
endfunction

`endif

// File: bench/tb_translation_unit.sv
`timescale 1ns/100ps

module tb_translation_unit import tu_pkg::*; ();

    logic        clk;
    logic        resetn;
    vaddr_u      i_ireq;
    vaddr_u      i_dreq;
    logic        i_k0_uncached;
    tu_op_req_t  i_op;
    tu_resp_t    o_iresp;
    tu_resp_t    o_dresp;
    tu_fault_t   o_ifault;
    tu_fault_t   o_dfault;
    tu_op_resp_t o_op_resp;
    logic        o_op_done;

    logic        xlate_chk;    // Translations are compared while set
    tu_op_resp_t exp_op_resp;
    logic        idx_care;     // A missed probe leaves the index open
    logic [7:0]  cur_asid;
    int          errors;
    int          test_start_errors;
    int          tests_run;
    int          tests_failed;

    `include "tb_model.svh"

    translation_unit i_translation_unit (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic void check_port(string name, vaddr_u va, tu_resp_t got, tu_fault_t gotf);
        tu_resp_t  er;
        tu_fault_t ef;
        ref_translate(va, i_op.entryhi.asid, i_k0_uncached, er, ef);
        assert (gotf == ef && (ef.refill || got == er)) else begin  // No paddr on refill
            errors++;
            $display("Fail at %0t: %s vaddr %h gave %h/%b/%b, expected %h/%b/%b", $time, name,
                     va, got.paddr, got.uncached, gotf, er.paddr, er.uncached, ef);
        end
    endfunction

    // ********************
    // Comparing process
    // ********************
    always @(negedge clk) begin
        tu_op_resp_t got;
        if (xlate_chk) begin
            check_port("ifetch", i_ireq, o_iresp, o_ifault);
            check_port("data", i_dreq, o_dresp, o_dfault);
        end
        if (o_op_done) begin
            got = o_op_resp;
            if (!idx_care) got.index.index = exp_op_resp.index.index;
            assert (got == exp_op_resp) else begin
                errors++;
                $display("Fail at %0t: op result %h, expected %h", $time, o_op_resp, exp_op_resp);
            end
        end
    end

    function automatic logic [7:0] rand_asid();
        return 8'(($urandom % 3) + 1);
    endfunction

    function automatic entrylo_t rand_lo();
        logic [31:0] r;
        r = $urandom;
        return '{fill: '0, pfn: r[19:0], c: r[22:20], d: r[23], v: r[24] | r[25], g: r[26]};
    endfunction

    // Keeps the pair out of kseg0 and kseg1
    function automatic logic [18:0] mapped_vpn2(logic [3:0] low);
        logic [31:0] r;
        r = $urandom;
        if (r[18:17] == 2'b10) r[17] = 1'b1;
        return {r[18:4], low};
    endfunction

    function automatic word_t pick_addr();
        logic [31:0] r;
        logic [31:0] a;
        r = $urandom;
        a = $urandom;
        if (r[5:4] != 2'b00) a[31:13] = model_tlb[r[3:0]].vpn2;
        else if (a[31:30] == 2'b10) a[30] = 1'b1;
        return a;
    endfunction

    task automatic translate(input word_t ia, input word_t da, input logic k0u);
        @(posedge clk);
        i_ireq        <= ia;
        i_dreq        <= da;
        i_k0_uncached <= k0u;
        xlate_chk     <= 1'b1;
        @(negedge clk);
    endtask

    task automatic set_asid(input logic [7:0] asid);
        @(posedge clk);
        cur_asid = asid;
        i_op.entryhi.asid <= asid;
    endtask

    task automatic run_op(input tu_op_e kind, input tlb_idx_t idx, input entryhi_t hi,
                          input entrylo_t lo0, input entrylo_t lo1);
        int waited;
        @(posedge clk);
        xlate_chk <= 1'b0;
        i_op <= '{valid: 1'b1, op: kind, index: '{p: 1'b0, zero: '0, index: idx},
                  entryhi: hi, entrylo0: lo0, entrylo1: lo1};
        case (kind)
            OP_TLBWI: model_write(idx, hi, lo0, lo1);
            OP_TLBR:  exp_op_resp = ref_read(exp_op_resp, idx);
            default: begin
                exp_op_resp.index = ref_probe(hi);
                idx_care          = ~exp_op_resp.index.p;
            end
        endcase
        @(posedge clk);
        i_op.valid   <= 1'b0;
        i_op.entryhi <= '{vpn2: '0, zero: '0, asid: cur_asid};
        waited = 0;
        @(negedge clk);
        while (!o_op_done && waited < 20) begin
            waited++;
            @(negedge clk);
        end
        assert (o_op_done && waited == 0) else begin
            errors++;
            if (o_op_done) $display("Fail at %0t: o_op_done rose %0d cycles late", $time, waited);
            else $display("Timeout: o_op_done did not rise within 20 cycles of the operation");
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_start_errors) tests_failed++;
        $display("Test %s: %s, %0d errors", name,
                 (errors == test_start_errors) ? "ok" : "failed", errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [18:0] vp;
        entryhi_t    hi;
        entrylo_t    lo;
        r             = $urandom(32'hc8ec_986d);
        resetn        = 1'b0;
        i_ireq        = '0;
        i_dreq        = '0;
        i_k0_uncached = 1'b0;
        i_op          = '0;
        xlate_chk     = 1'b0;
        exp_op_resp   = '0;
        idx_care      = 1'b1;
        cur_asid      = '0;
        errors        = 0;
        test_start_errors = 0;
        tests_run     = 0;
        tests_failed  = 0;
        model_reset();
        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        @(negedge clk);
        assert (!o_op_done && o_op_resp == '0) else begin
            errors++;
            $display("Fail at %0t: done %b, op result %h after reset", $time, o_op_done, o_op_resp);
        end
        set_asid(8'h5a);
        translate(32'h0040_3000, 32'hc012_5000, 1'b0);
        assert (o_ifault.refill && o_dfault.refill) else begin
            errors++;
            $display("Fail at %0t: empty table did not refill", $time);
        end
        finish_test("reset state");

        for (int n = 0; n < 40; n++) begin
            r  = $urandom;
            r2 = $urandom;
            r[31:30]  = 2'b10;  // Bit 29 picks kseg0 or kseg1
            r2[31:30] = 2'b10;
            translate(r, r2, n[0]);
        end
        finish_test("unmapped");

        set_asid(8'd1);
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hi = '{vpn2: mapped_vpn2(4'(i)), zero: '0, asid: rand_asid()};
            run_op(OP_TLBWI, tlb_idx_t'(i), hi, rand_lo(), rand_lo());
        end
        for (int n = 0; n < 60; n++) begin
            if (n % 20 == 0) set_asid(rand_asid());
            translate(pick_addr(), pick_addr(), 1'b0);
        end
        finish_test("write and translate");

        // Index 3 goes in first so that write order cannot decide the winner
        vp = mapped_vpn2(4'h3);
        hi = '{vpn2: vp, zero: '0, asid: 8'd7};
        lo = '{fill: '0, pfn: 20'h33333, c: 3'd3, d: 1'b1, v: 1'b1, g: 1'b1};
        run_op(OP_TLBWI, 4'd3, hi, lo, lo);
        lo.pfn = 20'h11111;
        run_op(OP_TLBWI, 4'd9, hi, lo, lo);
        translate({vp, 13'h0abc}, {vp, 13'h1abc}, 1'b0);
        assert (o_iresp.paddr == 32'h3333_3abc && o_dresp.paddr == 32'h3333_3abc) else begin
            errors++;
            $display("Fail at %0t: priority gave %h and %h", $time, o_iresp.paddr, o_dresp.paddr);
        end
        run_op(OP_TLBP, 4'd0, hi, lo, lo);
        assert (!o_op_resp.index.p && o_op_resp.index.index == 4'd3) else begin
            errors++;
            $display("Fail at %0t: probe gave index %h", $time, o_op_resp.index);
        end
        finish_test("priority");

        for (int n = 0; n < 24; n++) begin
            r  = $urandom;
            vp = r[4] ? model_tlb[r[3:0]].vpn2 : mapped_vpn2(r[8:5]);
            hi = '{vpn2: vp, zero: '0, asid: rand_asid()};
            run_op(OP_TLBP, 4'd0, hi, '0, '0);
        end
        finish_test("tlbp");

        for (int n = 0; n < 16; n++) begin
            r = $urandom;
            run_op(OP_TLBR, r[3:0], hi, '0, '0);
        end
        finish_test("tlbr");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: common/tu_pkg.sv
package tu_pkg;

    // ********************
    // Sizes and encodings
    // ********************
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;
    localparam logic [2:0] C_UNCACHED = 3'd2;  // Cache attribute of an uncached page

    typedef logic [31:0]          word_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

    // One virtual address word, seen either as page fields or as segment bits
    typedef union packed {
        struct packed {
            logic [18:0] vpn2;
            logic        odd;     // Selects the odd page of the pair
            logic [11:0] offset;
        } page;
        struct packed {
            logic [2:0]  seg;
            logic [28:0] rest;
        } segv;
    } vaddr_u;

    // One stored entry, covering an even/odd page pair
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    // ********************
    // CP0 register layouts
    // ********************
    typedef struct packed {
        logic [5:0]  fill;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } entrylo_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  zero;
        logic [7:0]  asid;
    } entryhi_t;

    typedef struct packed {
        logic                  p;     // Set when a probe misses
        logic [30-TLB_IDX_W:0] zero;
        tlb_idx_t              index;
    } index_t;

    typedef enum logic [1:0] {
        OP_TLBR  = 2'd0,
        OP_TLBWI = 2'd1,
        OP_TLBP  = 2'd2
    } tu_op_e;

    typedef struct packed {
        logic     valid;
        tu_op_e   op;
        index_t   index;
        entryhi_t entryhi;
        entrylo_t entrylo0;
        entrylo_t entrylo1;
    } tu_op_req_t;

    typedef struct packed {
        index_t   index;
        entryhi_t entryhi;
        entrylo_t entrylo0;
        entrylo_t entrylo1;
    } tu_op_resp_t;

    // ********************
    // Internal transfers
    // ********************
    typedef struct packed {
        logic       valid;
        tlb_idx_t   idx;
        tlb_entry_t entry;
    } tlb_write_t;

    // Page fields belong to the selected page of the winning entry
    typedef struct packed {
        logic        hit;
        tlb_idx_t    idx;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
    } lookup_resp_t;

    typedef struct packed {
        word_t paddr;
        logic  uncached;
    } tu_resp_t;

    typedef struct packed {
        logic refill;
        logic invalid;
        logic modified;
    } tu_fault_t;

    typedef struct packed {
        logic  mapped;
        word_t paddr;
        logic  uncached;
    } seg_resp_t;

endpackage

// File: hw/seg_map.sv
`timescale 1ns/100ps

module seg_map import tu_pkg::*; (
    input  vaddr_u    i_vaddr,
    input  logic      i_k0_uncached,
    output seg_resp_t o_seg
);

    logic is_kseg0, is_kseg1;

    // kseg0 is 0x8000_0000 and kseg1 is 0xa000_0000, each 512 MB
    assign is_kseg0 = (i_vaddr.segv.seg == 3'b100);
    assign is_kseg1 = (i_vaddr.segv.seg == 3'b101);

    assign o_seg.mapped = ~(is_kseg0 | is_kseg1);

    // Direct mapping drops the segment bits
    assign o_seg.paddr = {3'b000, i_vaddr.segv.rest};

    assign o_seg.uncached = is_kseg1 | (is_kseg0 & i_k0_uncached);

endmodule

// File: hw/translation_unit.sv
`timescale 1ns/100ps

module translation_unit import tu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  vaddr_u      i_ireq,
    input  vaddr_u      i_dreq,
    input  logic        i_k0_uncached,
    input  tu_op_req_t  i_op,
    output tu_resp_t    o_iresp,
    output tu_resp_t    o_dresp,
    output tu_fault_t   o_ifault,
    output tu_fault_t   o_dfault,
    output tu_op_resp_t o_op_resp,
    output logic        o_op_done
);

    tlb_write_t   write;
    tlb_idx_t     rd_idx;
    tlb_entry_t   rd_entry;
    tlb_entry_t   [TLB_ENTRIES-1:0] entries;
    lookup_resp_t ilook, dlook, plook;
    seg_resp_t    iseg, dseg;
    vaddr_u       probe_key;

    assign probe_key = i_op.entryhi;  // Only the VPN2 bits take part in the probe match

    tu_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .i_op       (i_op),
        .i_rd_entry (rd_entry),
        .i_ilook    (ilook),
        .i_dlook    (dlook),
        .i_plook    (plook),
        .i_iseg     (iseg),
        .i_dseg     (dseg),
        .o_write    (write),
        .o_rd_idx   (rd_idx),
        .o_iresp    (o_iresp),
        .o_dresp    (o_dresp),
        .o_ifault   (o_ifault),
        .o_dfault   (o_dfault),
        .o_op_resp  (o_op_resp),
        .o_op_done  (o_op_done)
    );

    tlb_table u_table (
        .clk        (clk),
        .resetn     (resetn),
        .i_write    (write),
        .i_rd_idx   (rd_idx),
        .o_rd_entry (rd_entry),
        .o_entries  (entries)
    );

    tlb_lookup u_ilookup (.i_entries(entries), .i_key(i_ireq), .i_asid(i_op.entryhi.asid),
                          .o_resp(ilook));
    tlb_lookup u_dlookup (.i_entries(entries), .i_key(i_dreq), .i_asid(i_op.entryhi.asid),
                          .o_resp(dlook));
    tlb_lookup u_plookup (.i_entries(entries), .i_key(probe_key), .i_asid(i_op.entryhi.asid),
                          .o_resp(plook));

    seg_map u_iseg (.i_vaddr(i_ireq), .i_k0_uncached(i_k0_uncached), .o_seg(iseg));
    seg_map u_dseg (.i_vaddr(i_dreq), .i_k0_uncached(i_k0_uncached), .o_seg(dseg));

endmodule

// File: hw/tu_ctrl.sv
`timescale 1ns/100ps

module tu_ctrl import tu_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    input  tu_op_req_t   i_op,
    input  tlb_entry_t   i_rd_entry,
    input  lookup_resp_t i_ilook,
    input  lookup_resp_t i_dlook,
    input  lookup_resp_t i_plook,
    input  seg_resp_t    i_iseg,
    input  seg_resp_t    i_dseg,
    output tlb_write_t   o_write,
    output tlb_idx_t     o_rd_idx,
    output tu_resp_t     o_iresp,
    output tu_resp_t     o_dresp,
    output tu_fault_t    o_ifault,
    output tu_fault_t    o_dfault,
    output tu_op_resp_t  o_op_resp,
    output logic         o_op_done
);

    logic        do_read, do_probe;
    tu_op_resp_t resp_q;
    logic        done_q;

    // The low 12 bits of the direct address are always the page offset
    function automatic tu_resp_t pick_resp(seg_resp_t seg, lookup_resp_t look);
        tu_resp_t r;
        r.paddr    = seg.mapped ? {look.pfn, seg.paddr[11:0]} : seg.paddr;
        r.uncached = seg.mapped ? (look.c == C_UNCACHED) : seg.uncached;
        return r;
    endfunction

    function automatic tu_fault_t classify(seg_resp_t seg, lookup_resp_t look);
        tu_fault_t f;
        f.refill   = seg.mapped & ~look.hit;
        f.invalid  = seg.mapped & look.hit & ~look.v;
        f.modified = seg.mapped & look.hit & look.v & ~look.d;  // No store flag on the ports
        return f;
    endfunction

    assign do_read  = i_op.valid && (i_op.op == OP_TLBR);
    assign do_probe = i_op.valid && (i_op.op == OP_TLBP);

    // ********************
    // TLBWI entry packing
    // ********************
    assign o_write.valid      = i_op.valid && (i_op.op == OP_TLBWI);
    assign o_write.idx        = i_op.index.index;
    assign o_write.entry.vpn2 = i_op.entryhi.vpn2;
    assign o_write.entry.asid = i_op.entryhi.asid;
    assign o_write.entry.g    = i_op.entrylo0.g & i_op.entrylo1.g;
    assign o_write.entry.pfn0 = i_op.entrylo0.pfn;
    assign o_write.entry.c0   = i_op.entrylo0.c;
    assign o_write.entry.d0   = i_op.entrylo0.d;
    assign o_write.entry.v0   = i_op.entrylo0.v;
    assign o_write.entry.pfn1 = i_op.entrylo1.pfn;
    assign o_write.entry.c1   = i_op.entrylo1.c;
    assign o_write.entry.d1   = i_op.entrylo1.d;
    assign o_write.entry.v1   = i_op.entrylo1.v;

    assign o_rd_idx = i_op.index.index;

    // ********************
    // TLBR / TLBP results
    // ********************
    always_ff @(posedge clk) begin
        if (!resetn) begin
            resp_q <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= i_op.valid;  // Every operation finishes one cycle after its strobe
            if (do_read) begin
                resp_q.entryhi  <= '{vpn2: i_rd_entry.vpn2, zero: '0, asid: i_rd_entry.asid};
                resp_q.entrylo0 <= '{fill: '0, pfn: i_rd_entry.pfn0, c: i_rd_entry.c0,
                                     d: i_rd_entry.d0, v: i_rd_entry.v0, g: i_rd_entry.g};
                resp_q.entrylo1 <= '{fill: '0, pfn: i_rd_entry.pfn1, c: i_rd_entry.c1,
                                     d: i_rd_entry.d1, v: i_rd_entry.v1, g: i_rd_entry.g};
            end
            if (do_probe) begin
                resp_q.index <= '{p: ~i_plook.hit, zero: '0, index: i_plook.idx};
            end
        end
    end

    assign o_op_resp = resp_q;
    assign o_op_done = done_q;

    assign o_iresp  = pick_resp(i_iseg, i_ilook);
    assign o_dresp  = pick_resp(i_dseg, i_dlook);
    assign o_ifault = classify(i_iseg, i_ilook);
    assign o_dfault = classify(i_dseg, i_dlook);

endmodule

// File: list.f
+incdir+bench
common/tu_pkg.sv
tlb/tlb_table.sv
tlb/tlb_lookup.sv
hw/seg_map.sv
hw/tu_ctrl.sv
hw/translation_unit.sv
bench/tb_translation_unit.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir \
    --top-module tb_translation_unit -f list.f \
    && ./obj_dir/Vtb_translation_unit | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tlb/tlb_lookup.sv
`timescale 1ns/100ps

module tlb_lookup import tu_pkg::*; (
    input  tlb_entry_t   [TLB_ENTRIES-1:0] i_entries,
    input  vaddr_u       i_key,
    input  logic [7:0]   i_asid,
    output lookup_resp_t o_resp
);

    logic [TLB_ENTRIES-1:0] match;
    tlb_idx_t               hit_idx;
    tlb_entry_t             sel;

    // ********************
    // Match mask
    // ********************
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_match
        assign match[i] = (i_entries[i].vpn2 == i_key.page.vpn2) &&
                          ((i_entries[i].asid == i_asid) || i_entries[i].g);
    end

    // Lowest matching index wins, so scan from the top down
    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign sel = i_entries[hit_idx];

    assign o_resp.hit = |match;
    assign o_resp.idx = hit_idx;

    // Page pair select
    always_comb begin
        if (i_key.page.odd) begin
            o_resp.pfn = sel.pfn1;
            o_resp.c   = sel.c1;
            o_resp.d   = sel.d1;
            o_resp.v   = sel.v1;
        end else begin
            o_resp.pfn = sel.pfn0;
            o_resp.c   = sel.c0;
            o_resp.d   = sel.d0;
            o_resp.v   = sel.v0;
        end
    end

endmodule

// File: tlb/tlb_table.sv
`timescale 1ns/100ps

module tlb_table import tu_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  tlb_write_t i_write,
    input  tlb_idx_t   i_rd_idx,
    output tlb_entry_t o_rd_entry,
    output tlb_entry_t [TLB_ENTRIES-1:0] o_entries
);

    tlb_entry_t [TLB_ENTRIES-1:0] table_q;

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        always_ff @(posedge clk) begin
            if (!resetn) begin
                table_q[i] <= '0;
            end else if (i_write.valid && (i_write.idx == tlb_idx_t'(i))) begin
                table_q[i] <= i_write.entry;  // Visible to lookups from the next cycle
            end
        end
    end

    assign o_rd_entry = table_q[i_rd_idx];
    assign o_entries  = table_q;

endmodule
